//--- src/sacc_pkg.sv
`default_nettype none

package sacc_pkg;

  // Link and datapath widths
  localparam int FLIT_W = 32;
  localparam int ELEM_W = 16;
  localparam int ACC_W  = 40;
  localparam int OP_W   = 3;
  localparam int ADDR_W = 8;

  // Opcode sits in the low bits of a header flit with the address right above
  localparam int OPC_LSB  = 0;
  localparam int ADDR_LSB = OPC_LSB + OP_W;

  // Zero is left unused so an all-zero flit is not a command
  typedef enum logic [OP_W-1:0] {
    OP_WRITE_A      = 3'd1,
    OP_WRITE_B      = 3'd2,
    OP_SET_LEN      = 3'd3,
    OP_START        = 3'd4,
    OP_READ_RESULT  = 3'd5,
    OP_READ_STATUS  = 3'd6,
    OP_RESP         = 3'd7
  } opcode_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_DONE = 2'd2
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- src/sacc_packet_rx.sv
`timescale 1ns/1ns
`default_nettype none

module sacc_packet_rx #(
  parameter int VEC_DEPTH = 8
) (
  input  wire logic                         clk_i,
  input  wire logic                         arst_n_i,
  input  wire logic [sacc_pkg::FLIT_W-1:0]  flit_i,
  input  wire logic                         flit_v_i,
  output logic                              cmd_v_o,
  output sacc_pkg::opcode_e                 cmd_op_o,
  output logic [sacc_pkg::ADDR_W-1:0]       cmd_addr_o,
  output logic [sacc_pkg::ELEM_W-1:0]       cmd_data_o
);

  localparam int AW = sacc_pkg::ADDR_W;
  // Depth is a power of two, so the mask keeps only the index bits
  localparam logic [AW-1:0] ADDR_MASK = AW'(VEC_DEPTH - 1);

  sacc_pkg::opcode_e flit_op;
  logic [AW-1:0]     flit_addr;
  logic              has_data;

  logic              pending_q;
  sacc_pkg::opcode_e hdr_op_q;
  logic [AW-1:0]     hdr_addr_q;

  assign flit_op   = sacc_pkg::opcode_e'(flit_i[sacc_pkg::OPC_LSB +: sacc_pkg::OP_W]);
  assign flit_addr = flit_i[sacc_pkg::ADDR_LSB +: AW] & ADDR_MASK;

  // Only element writes and SET_LEN carry a data flit
  assign has_data = (flit_op == sacc_pkg::OP_WRITE_A) ||
                    (flit_op == sacc_pkg::OP_WRITE_B) ||
                    (flit_op == sacc_pkg::OP_SET_LEN);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 1'b0;
      cmd_v_o   <= 1'b0;
    end else begin
      cmd_v_o <= 1'b0;
      if (flit_v_i) begin
        if (pending_q) begin
          pending_q <= 1'b0;
          cmd_v_o   <= 1'b1;
        end else if (has_data) begin
          pending_q <= 1'b1;
        end else begin
          cmd_v_o <= 1'b1;
        end
      end
    end
  end

  // Header latch and command payload
  always_ff @(posedge clk_i) begin
    if (flit_v_i) begin
      if (pending_q) begin
        cmd_op_o   <= hdr_op_q;
        cmd_addr_o <= hdr_addr_q;
        cmd_data_o <= flit_i[sacc_pkg::ELEM_W-1:0];
      end else if (has_data) begin
        hdr_op_q   <= flit_op;
        hdr_addr_q <= flit_addr;
      end else begin
        cmd_op_o   <= flit_op;
        cmd_addr_o <= flit_addr;
        cmd_data_o <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/sacc_ctrl_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module sacc_ctrl_fsm #(
  parameter int VEC_DEPTH = 8
) (
  input  wire logic                         clk_i,
  input  wire logic                         arst_n_i,
  input  wire logic                         cmd_v_i,
  input  sacc_pkg::opcode_e                 cmd_op_i,
  input  wire logic [$clog2(VEC_DEPTH+1)-1:0] run_len_i,
  input  wire logic                         last_elem_i,
  output sacc_pkg::ctrl_state_e             state_o,
  output logic                              cnt_clr_o,
  output logic                              cnt_en_o,
  output logic                              clear_acc_o,
  output logic                              acc_en_o,
  output logic                              done_set_o
);

  sacc_pkg::ctrl_state_e state_q;
  sacc_pkg::ctrl_state_e state_d;
  logic                  start_ok;
  logic                  running;

  // A START while running is dropped
  assign start_ok = cmd_v_i && (cmd_op_i == sacc_pkg::OP_START) &&
                    (state_q != sacc_pkg::ST_RUN);
  assign running  = (state_q == sacc_pkg::ST_RUN);

  always_comb begin
    state_d = state_q;
    case (state_q)
      sacc_pkg::ST_IDLE,
      sacc_pkg::ST_DONE: begin
        if (start_ok) begin
          // Zero length has nothing to run
          state_d = (run_len_i == '0) ? sacc_pkg::ST_DONE : sacc_pkg::ST_RUN;
        end
      end
      sacc_pkg::ST_RUN: begin
        if (last_elem_i) begin
          state_d = sacc_pkg::ST_DONE;
        end
      end
      default: state_d = sacc_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= sacc_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o     = state_q;
  assign cnt_clr_o   = start_ok;
  assign clear_acc_o = start_ok;
  assign cnt_en_o    = running;
  assign acc_en_o    = running;
  assign done_set_o  = running && last_elem_i;

endmodule

`default_nettype wire

//--- src/sacc_elem_counter.sv
`timescale 1ns/1ns
`default_nettype none

module sacc_elem_counter #(
  parameter int VEC_DEPTH = 8
) (
  input  wire logic                           clk_i,
  input  wire logic                           arst_n_i,
  input  wire logic                           cnt_clr_i,
  input  wire logic                           cnt_en_i,
  input  wire logic [$clog2(VEC_DEPTH+1)-1:0] run_len_i,
  output logic [$clog2(VEC_DEPTH)-1:0]        elem_idx_o,
  output logic                                last_elem_o
);

  localparam int LEN_W = $clog2(VEC_DEPTH + 1);
  localparam int IDX_W = $clog2(VEC_DEPTH);

  logic [IDX_W-1:0] idx_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      idx_q <= '0;
    end else if (cnt_clr_i) begin
      idx_q <= '0;
    end else if (cnt_en_i) begin
      idx_q <= idx_q + IDX_W'(1);
    end
  end

  assign elem_idx_o  = idx_q;
  // Terminal count on the last element of the run
  assign last_elem_o = (LEN_W'(idx_q) == (run_len_i - LEN_W'(1)));

endmodule

`default_nettype wire

//--- src/sacc_vdp_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module sacc_vdp_datapath #(
  parameter int VEC_DEPTH = 8
) (
  input  wire logic                           clk_i,
  input  wire logic                           arst_n_i,
  input  wire logic                           cmd_v_i,
  input  sacc_pkg::opcode_e                   cmd_op_i,
  input  wire logic [sacc_pkg::ADDR_W-1:0]    cmd_addr_i,
  input  wire logic [sacc_pkg::ELEM_W-1:0]    cmd_data_i,
  input  sacc_pkg::ctrl_state_e               state_i,
  input  wire logic                           clear_acc_i,
  input  wire logic                           acc_en_i,
  input  wire logic                           done_set_i,
  input  wire logic [$clog2(VEC_DEPTH)-1:0]   elem_idx_i,
  output logic [$clog2(VEC_DEPTH+1)-1:0]      run_len_o,
  output logic                                rd_v_o,
  output logic [sacc_pkg::FLIT_W-1:0]         rd_data_o
);

  localparam int LEN_W = $clog2(VEC_DEPTH + 1);
  localparam int IDX_W = $clog2(VEC_DEPTH);
  localparam int EW    = sacc_pkg::ELEM_W;
  localparam int AW    = sacc_pkg::ACC_W;
  localparam int FW    = sacc_pkg::FLIT_W;

  logic [EW-1:0]    vec_a_q [VEC_DEPTH];
  logic [EW-1:0]    vec_b_q [VEC_DEPTH];
  logic [LEN_W-1:0] len_q;
  logic [AW-1:0]    acc_q;
  logic [AW-1:0]    result_q;

  logic             wr_ok;
  logic [IDX_W-1:0] wr_idx;
  logic [LEN_W-1:0] new_len;
  logic [2*EW-1:0]  prod;
  logic [AW-1:0]    mac_sum;
  logic [FW-1:0]    status_word;

  // Operands and length are frozen for the whole run
  assign wr_ok  = cmd_v_i && (state_i != sacc_pkg::ST_RUN);
  assign wr_idx = cmd_addr_i[IDX_W-1:0];

  // Lengths past the vector depth saturate
  assign new_len = (cmd_data_i > EW'(VEC_DEPTH)) ? LEN_W'(VEC_DEPTH) : LEN_W'(cmd_data_i);

  assign prod    = vec_a_q[elem_idx_i] * vec_b_q[elem_idx_i];
  assign mac_sum = acc_q + AW'(prod);

  assign status_word = {{(FW - LEN_W - 2){1'b0}}, len_q,
                        (state_i == sacc_pkg::ST_DONE), (state_i == sacc_pkg::ST_RUN)};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < VEC_DEPTH; i++) begin
        vec_a_q[i] <= '0;
        vec_b_q[i] <= '0;
      end
      len_q <= '0;
    end else if (wr_ok) begin
      case (cmd_op_i)
        sacc_pkg::OP_WRITE_A: vec_a_q[wr_idx] <= cmd_data_i;
        sacc_pkg::OP_WRITE_B: vec_b_q[wr_idx] <= cmd_data_i;
        sacc_pkg::OP_SET_LEN: len_q <= new_len;
        default: ;
      endcase
    end
  end

  // Result takes the final sum including the last product
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_q    <= '0;
      result_q <= '0;
    end else if (clear_acc_i) begin
      acc_q    <= '0;
      result_q <= '0;
    end else begin
      if (acc_en_i) begin
        acc_q <= mac_sum;
      end
      if (done_set_i) begin
        result_q <= mac_sum;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_v_o <= 1'b0;
    end else begin
      rd_v_o <= cmd_v_i && ((cmd_op_i == sacc_pkg::OP_READ_RESULT) ||
                            (cmd_op_i == sacc_pkg::OP_READ_STATUS));
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_v_i) begin
      rd_data_o <= (cmd_op_i == sacc_pkg::OP_READ_RESULT) ? result_q[FW-1:0] : status_word;
    end
  end

  assign run_len_o = len_q;

endmodule

`default_nettype wire

//--- src/sacc_resp_tx.sv
`timescale 1ns/1ns
`default_nettype none

module sacc_resp_tx (
  input  wire logic                         clk_i,
  input  wire logic                         arst_n_i,
  input  wire logic                         rd_v_i,
  input  wire logic [sacc_pkg::FLIT_W-1:0]  rd_data_i,
  output logic [sacc_pkg::FLIT_W-1:0]       resp_flit_o,
  output logic                              resp_v_o
);

  logic                        beat2_q;
  logic [sacc_pkg::FLIT_W-1:0] data_q;
  logic [sacc_pkg::FLIT_W-1:0] hdr_flit;

  // Response header has OP_RESP and a zero address
  always_comb begin
    hdr_flit = '0;
    hdr_flit[sacc_pkg::OPC_LSB +: sacc_pkg::OP_W] = sacc_pkg::OP_RESP;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat2_q <= 1'b0;
    end else begin
      beat2_q <= rd_v_i;
    end
  end

  // Held for the data beat
  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      data_q <= rd_data_i;
    end
  end

  // rd_v_i comes straight from a register so the header leaves in the same cycle
  assign resp_v_o    = rd_v_i || beat2_q;
  assign resp_flit_o = rd_v_i ? hdr_flit : data_q;

endmodule

`default_nettype wire

//--- src/sacc_tile.sv
`timescale 1ns/1ns
`default_nettype none

module sacc_tile #(
  parameter int VEC_DEPTH = 8
) (
  input  wire logic                         clk_i,
  input  wire logic                         arst_n_i,
  input  wire logic [sacc_pkg::FLIT_W-1:0]  flit_i,
  input  wire logic                         flit_v_i,
  output logic [sacc_pkg::FLIT_W-1:0]       resp_flit_o,
  output logic                              resp_v_o
);

  localparam int LEN_W = $clog2(VEC_DEPTH + 1);
  localparam int IDX_W = $clog2(VEC_DEPTH);

  logic                        cmd_v;
  sacc_pkg::opcode_e           cmd_op;
  logic [sacc_pkg::ADDR_W-1:0] cmd_addr;
  logic [sacc_pkg::ELEM_W-1:0] cmd_data;

  sacc_pkg::ctrl_state_e       state;
  logic                        cnt_clr;
  logic                        cnt_en;
  logic                        clear_acc;
  logic                        acc_en;
  logic                        done_set;

  logic [IDX_W-1:0]            elem_idx;
  logic                        last_elem;
  logic [LEN_W-1:0]            run_len;

  logic                        rd_v;
  logic [sacc_pkg::FLIT_W-1:0] rd_data;

  sacc_packet_rx #(.VEC_DEPTH(VEC_DEPTH)) sacc_packet_rx_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .flit_i     (flit_i),
    .flit_v_i   (flit_v_i),
    .cmd_v_o    (cmd_v),
    .cmd_op_o   (cmd_op),
    .cmd_addr_o (cmd_addr),
    .cmd_data_o (cmd_data)
  );

  sacc_ctrl_fsm #(.VEC_DEPTH(VEC_DEPTH)) sacc_ctrl_fsm_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cmd_v_i     (cmd_v),
    .cmd_op_i    (cmd_op),
    .run_len_i   (run_len),
    .last_elem_i (last_elem),
    .state_o     (state),
    .cnt_clr_o   (cnt_clr),
    .cnt_en_o    (cnt_en),
    .clear_acc_o (clear_acc),
    .acc_en_o    (acc_en),
    .done_set_o  (done_set)
  );

  sacc_elem_counter #(.VEC_DEPTH(VEC_DEPTH)) sacc_elem_counter_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cnt_clr_i   (cnt_clr),
    .cnt_en_i    (cnt_en),
    .run_len_i   (run_len),
    .elem_idx_o  (elem_idx),
    .last_elem_o (last_elem)
  );

  sacc_vdp_datapath #(.VEC_DEPTH(VEC_DEPTH)) sacc_vdp_datapath_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cmd_v_i     (cmd_v),
    .cmd_op_i    (cmd_op),
    .cmd_addr_i  (cmd_addr),
    .cmd_data_i  (cmd_data),
    .state_i     (state),
    .clear_acc_i (clear_acc),
    .acc_en_i    (acc_en),
    .done_set_i  (done_set),
    .elem_idx_i  (elem_idx),
    .run_len_o   (run_len),
    .rd_v_o      (rd_v),
    .rd_data_o   (rd_data)
  );

  sacc_resp_tx sacc_resp_tx_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .rd_v_i      (rd_v),
    .rd_data_i   (rd_data),
    .resp_flit_o (resp_flit_o),
    .resp_v_o    (resp_v_o)
  );

endmodule

`default_nettype wire

//--- dv/sacc_tile_sva.sv
`timescale 1ns/1ns
`default_nettype none

module sacc_tile_sva (
  input wire logic                        clk_i,
  input wire logic                        arst_n_i,
  input wire logic [sacc_pkg::FLIT_W-1:0] flit_i,
  input wire logic                        flit_v_i,
  input wire logic                        resp_v_i
);

  sacc_pkg::opcode_e in_op;
  logic              in_has_data;
  logic              in_pending_q;
  logic              read_hdr;
  logic              hdr_beat;
  logic              data_beat_q;

  assign in_op       = sacc_pkg::opcode_e'(flit_i[sacc_pkg::OPC_LSB +: sacc_pkg::OP_W]);
  assign in_has_data = (in_op == sacc_pkg::OP_WRITE_A) || (in_op == sacc_pkg::OP_WRITE_B) ||
                       (in_op == sacc_pkg::OP_SET_LEN);
  // A flit is a header unless a data flit is owed
  assign read_hdr    = flit_v_i && !in_pending_q &&
                       ((in_op == sacc_pkg::OP_READ_RESULT) ||
                        (in_op == sacc_pkg::OP_READ_STATUS));
  assign hdr_beat    = resp_v_i && !data_beat_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_pending_q <= 1'b0;
      data_beat_q  <= 1'b0;
    end else begin
      if (flit_v_i) begin
        in_pending_q <= !in_pending_q && in_has_data;
      end
      data_beat_q <= hdr_beat;
    end
  end

  quiet_in_reset_a: assert property (@(posedge clk_i) !arst_n_i |-> !resp_v_i)
    else $error("resp_v_o high during reset");

  quiet_after_reset_a: assert property (@(posedge clk_i) $rose(arst_n_i) |-> !resp_v_i)
    else $error("resp_v_o high in the cycle after reset");

  data_follows_hdr_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    hdr_beat |=> resp_v_i)
    else $error("response header without a data beat");

  hdr_needs_read_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    hdr_beat |-> $past(read_hdr, 2))
    else $error("response header without a read two cycles earlier");

endmodule

`default_nettype wire

//--- dv/sacc_tile_tb.sv
`timescale 1ns/1ns
`default_nettype none

module sacc_tile_tb;

  localparam int VEC_DEPTH = 8;
  localparam int FW        = sacc_pkg::FLIT_W;
  localparam int EW        = sacc_pkg::ELEM_W;
  localparam int WAIT_MAX  = 20;
  localparam int POLL_MAX  = 12;
  localparam logic [FW-1:0] RESP_HDR = FW'(sacc_pkg::OP_RESP) << sacc_pkg::OPC_LSB;

  logic          clk;
  logic          arst_n;
  logic [FW-1:0] flit;
  logic          flit_v;
  logic [FW-1:0] resp_flit;
  logic          resp_v;
  logic          data_beat_q;
  int            value_errs = 0;
  int            timeout_errs = 0;

  // Reference model of the tile registers
  logic [EW-1:0] model_a [VEC_DEPTH];
  logic [EW-1:0] model_b [VEC_DEPTH];
  int            model_len;

  sacc_tile #(.VEC_DEPTH(VEC_DEPTH)) sacc_tile_i (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .flit_i      (flit),
    .flit_v_i    (flit_v),
    .resp_flit_o (resp_flit),
    .resp_v_o    (resp_v)
  );

  bind sacc_tile sacc_tile_sva sacc_tile_sva_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flit_i   (flit_i),
    .flit_v_i (flit_v_i),
    .resp_v_i (resp_v_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_beat_q <= 1'b0;
    end else begin
      data_beat_q <= resp_v && !data_beat_q;
    end
  end

  // First beat of every response is the OP_RESP header
  resp_hdr_a: assert property (@(posedge clk) disable iff (!arst_n)
    (resp_v && !data_beat_q) |-> (resp_flit == RESP_HDR))
  else begin
    value_errs++;
    $display("[ERROR] %0t resp_flit_o header expected 0x%08h actual 0x%08h",
             $time, RESP_HDR, $sampled(resp_flit));
  end

  function automatic logic [FW-1:0] hdr_flit(sacc_pkg::opcode_e op, int addr);
    logic [FW-1:0] f;
    f = '0;
    f[sacc_pkg::OPC_LSB +: sacc_pkg::OP_W]     = op;
    f[sacc_pkg::ADDR_LSB +: sacc_pkg::ADDR_W] = addr[sacc_pkg::ADDR_W-1:0];
    return f;
  endfunction

  function automatic logic [FW-1:0] expected_dot();
    logic [63:0] sum;
    sum = '0;
    for (int i = 0; i < model_len; i++) begin
      sum = sum + 64'(model_a[i]) * 64'(model_b[i]);
    end
    return sum[FW-1:0];
  endfunction

  function automatic logic [FW-1:0] expected_status(logic busy, logic done);
    logic [FW-1:0] s;
    s    = FW'(model_len) << 2;
    s[0] = busy;
    s[1] = done;
    return s;
  endfunction

  // Starts and ends on a rising edge
  task automatic drive_flit(logic [FW-1:0] data, int gap);
    flit   <= data;
    flit_v <= 1'b1;
    @(posedge clk);
    flit_v <= 1'b0;
    repeat (gap) @(posedge clk);
  endtask

  task automatic send_cmd(sacc_pkg::opcode_e op, int addr, logic [EW-1:0] data, bit tight);
    int gap_mid;
    int gap_end;
    gap_mid = tight ? 0 : int'($urandom % 3);
    gap_end = tight ? 1 : 1 + int'($urandom % 3);
    if (op == sacc_pkg::OP_WRITE_A || op == sacc_pkg::OP_WRITE_B ||
        op == sacc_pkg::OP_SET_LEN) begin
      drive_flit(hdr_flit(op, addr), gap_mid);
      drive_flit(FW'(data), gap_end);
    end else begin
      drive_flit(hdr_flit(op, addr), gap_end);
    end
  endtask

  task automatic read_reg(sacc_pkg::opcode_e op, output bit got, output logic [FW-1:0] data);
    int lat;
    lat  = 1;
    got  = 1'b0;
    data = '0;
    drive_flit(hdr_flit(op, 0), 0);
    @(negedge clk);
    while (!resp_v && lat < WAIT_MAX) begin
      @(negedge clk);
      lat++;
    end
    if (!resp_v) begin
      timeout_errs++;
      $display("Timed out waiting for the response to %s", op.name());
    end else begin
      assert (lat == 2) else begin
        value_errs++;
        $display("[ERROR] %0t resp_v_o latency expected 2 actual %0d", $time, lat);
      end
      @(negedge clk);
      assert (resp_v) else begin
        value_errs++;
        $display("[ERROR] %0t resp_v_o data beat expected 1 actual 0", $time);
      end
      got  = 1'b1;
      data = resp_flit;
    end
    @(posedge clk);
  endtask

  task automatic check_read(sacc_pkg::opcode_e op, logic [FW-1:0] exp);
    bit            got;
    logic [FW-1:0] data;
    read_reg(op, got, data);
    if (got) begin
      assert (data == exp) else begin
        value_errs++;
        $display("[ERROR] %0t resp_flit_o %s expected 0x%08h actual 0x%08h",
                 $time, op.name(), exp, data);
      end
    end
  endtask

  task automatic wait_done();
    int            polls;
    bit            got;
    bit            done;
    logic [FW-1:0] st;
    polls = 0;
    done  = 1'b0;
    while (!done && polls < POLL_MAX) begin
      read_reg(sacc_pkg::OP_READ_STATUS, got, st);
      polls++;
      if (got) begin
        assert (st == expected_status(1'b1, 1'b0) || st == expected_status(1'b0, 1'b1))
        else begin
          value_errs++;
          $display("[ERROR] %0t resp_flit_o status expected 0x%08h or 0x%08h actual 0x%08h",
                   $time, expected_status(1'b1, 1'b0), expected_status(1'b0, 1'b1), st);
        end
        done = st[1];
      end
    end
    if (!done) begin
      timeout_errs++;
      $display("Run did not finish within %0d status polls", POLL_MAX);
    end
  endtask

  initial begin
    void'($urandom(76884));
    arst_n    = 1'b0;
    flit      = '0;
    flit_v    = 1'b0;
    model_len = 0;
    for (int i = 0; i < VEC_DEPTH; i++) begin
      model_a[i] = '0;
      model_b[i] = '0;
    end
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    // Reset values
    check_read(sacc_pkg::OP_READ_STATUS, expected_status(1'b0, 1'b0));
    check_read(sacc_pkg::OP_READ_RESULT, '0);

    // Random runs with random flit gaps
    repeat (4) begin
      for (int i = 0; i < VEC_DEPTH; i++) begin
        model_a[i] = EW'($urandom);
        model_b[i] = EW'($urandom);
        send_cmd(sacc_pkg::OP_WRITE_A, i, model_a[i], 1'b0);
        send_cmd(sacc_pkg::OP_WRITE_B, i, model_b[i], 1'b0);
      end
      model_len = 1 + int'($urandom % VEC_DEPTH);
      send_cmd(sacc_pkg::OP_SET_LEN, 0, EW'(model_len), 1'b0);
      send_cmd(sacc_pkg::OP_START, 0, '0, 1'b0);
      wait_done();
      check_read(sacc_pkg::OP_READ_RESULT, expected_dot());
      check_read(sacc_pkg::OP_READ_STATUS, expected_status(1'b0, 1'b1));
    end

    // Packed commands land while a full-length run is busy
    model_len = VEC_DEPTH;
    send_cmd(sacc_pkg::OP_SET_LEN, 0, EW'(model_len), 1'b0);
    send_cmd(sacc_pkg::OP_START, 0, '0, 1'b1);
    send_cmd(sacc_pkg::OP_SET_LEN, 0, EW'(1), 1'b1);
    send_cmd(sacc_pkg::OP_WRITE_A, 0, ~model_a[0], 1'b1);
    wait_done();
    check_read(sacc_pkg::OP_READ_RESULT, expected_dot());
    check_read(sacc_pkg::OP_READ_STATUS, expected_status(1'b0, 1'b1));

    // Rerun on the same operands exposes a write that was not dropped
    send_cmd(sacc_pkg::OP_START, 0, '0, 1'b0);
    wait_done();
    check_read(sacc_pkg::OP_READ_RESULT, expected_dot());

    // Zero length
    model_len = 0;
    send_cmd(sacc_pkg::OP_SET_LEN, 0, '0, 1'b0);
    send_cmd(sacc_pkg::OP_START, 0, '0, 1'b0);
    check_read(sacc_pkg::OP_READ_STATUS, expected_status(1'b0, 1'b1));
    check_read(sacc_pkg::OP_READ_RESULT, '0);

    $display("Checks done with %0d value errors and %0d timeouts", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
src/sacc_pkg.sv
src/sacc_packet_rx.sv
src/sacc_ctrl_fsm.sv
src/sacc_elem_counter.sv
src/sacc_vdp_datapath.sv
src/sacc_resp_tx.sv
src/sacc_tile.sv
dv/sacc_tile_sva.sv
dv/sacc_tile_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module sacc_tile_tb -f vlog.f -o sim_tile
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tile)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
